// ==== dv/csrSubsystem_chk.sv ====
// ********************
// CSR subsystem assertions
// Latency, redirect qualification and trap cause
// ********************
`timescale 1ns/1ps
`default_nettype none

module csrSubsystem_chk (
    input logic                     clk,
    input logic                     arstN,
    input logic                     cmdValid,
    input logic                     rspValid,
    input csrOpPkg::csrRspT         rsp,
    input logic                     decValid,
    input csrOpPkg::csrDecodedT     dec
);

    int failCount = 0;

    // Fixed three-stage latency, one response per command
    latencyOk: assert property (@(posedge clk) disable iff (!arstN)
        rspValid == $past(cmdValid, 3))
        else begin
            failCount = failCount + 1;
            $error("rspValid does not follow cmdValid by 3 cycles");
        end

    redirectQualified: assert property (@(posedge clk) disable iff (!arstN)
        rsp.redirectValid |-> rspValid)
        else begin
            failCount = failCount + 1;
            $error("redirectValid high without rspValid");
        end

    trapCauseKnown: assert property (@(posedge clk) disable iff (!arstN)
        (decValid && dec.kind == csrOpPkg::kindTrap) |->
        (!dec.cause.trap.isInterrupt && (dec.cause.trap.code inside {
            csrRegPkg::trapIllegalInsn, csrRegPkg::trapBreakpoint,
            csrRegPkg::trapLoadMisaligned, csrRegPkg::trapStoreMisaligned,
            csrRegPkg::trapEcallM})))
        else begin
            failCount = failCount + 1;
            $error("decoded trap carries an unknown cause");
        end

endmodule

bind csrSubsystem csrSubsystem_chk uChk (
    .clk      (clk),
    .arstN    (arstN),
    .cmdValid (cmdValid),
    .rspValid (rspValid),
    .rsp      (rsp),
    .decValid (decValid),
    .dec      (dec)
);

`default_nettype wire

// ==== dv/csrSubsystem_tb.sv ====
// ********************
// CSR subsystem testbench
// Directed tests for CSR access, trap, mret, interrupts and counters
// ********************
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csrSubsystem_tb;

    localparam int numTests   = 6;
    localparam int cycleLimit = 40 * numTests + 20;

    logic                   clk = 1'b0;
    logic                   arstN;
    logic                   cmdValid;
    csrOpPkg::csrCmdT       cmd;
    logic                   timerIrq;
    logic                   externalIrq;
    logic                   rspValid;
    csrOpPkg::csrRspT       rsp;
    logic                   intPending;

    csrOpPkg::csrRspT       rspQ[$];
    logic [31:0]            rngState;
    int                     cycleCount;
    int                     valueErrors;
    int                     otherErrors;

    // Expected register state
    logic [31:0]            mscratchModel;
    logic [31:0]            mtvecModel;
    logic [31:0]            mepcModel;
    logic                   mieModel;
    logic                   mpieModel;

    csrSubsystem u_csrSubsystem (
        .clk         (clk),
        .arstN       (arstN),
        .cmdValid    (cmdValid),
        .cmd         (cmd),
        .timerIrq    (timerIrq),
        .externalIrq (externalIrq),
        .rspValid    (rspValid),
        .rsp         (rsp),
        .intPending  (intPending)
    );

    always #10 clk = ~clk;

    // Outputs only move on the rising edge
    always @(negedge clk) begin
        if (arstN && rspValid) begin
            rspQ.push_back(rsp);
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: no end of test after %0d cycles", cycleLimit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // SYSTEM opcode, rd = x1
    function automatic logic [31:0] makeInsn(input logic [11:0] num, input logic [2:0] f3,
                                             input logic [4:0] src);
        return {num, src, f3, 5'd1, 7'b1110011};
    endfunction

    function automatic csrOpPkg::csrCmdT accessCmd(input logic [11:0] num,
            input logic [2:0] f3, input logic [4:0] src, input logic [31:0] rs1);
        csrOpPkg::csrCmdT c;
        c          = '0;
        c.kind     = csrOpPkg::kindCsrAccess;
        c.insn     = makeInsn(num, f3, src);
        c.rs1Value = rs1;
        return c;
    endfunction

    function automatic csrOpPkg::csrRspT readRsp(input logic [31:0] data);
        csrOpPkg::csrRspT r;
        r          = '0;
        r.readData = data;
        return r;
    endfunction

    function automatic csrOpPkg::csrRspT redirectRsp(input logic [31:0] target,
                                                     input logic illegal);
        csrOpPkg::csrRspT r;
        r                = '0;
        r.redirectValid  = 1'b1;
        r.redirectTarget = target;
        r.isIllegal      = illegal;
        return r;
    endfunction

    function automatic logic [31:0] mstatusValue();
        return (32'(mpieModel) << `CSR_MPIE_BIT) | (32'(mieModel) << `CSR_MIE_BIT);
    endfunction

    task automatic sendCmd(input csrOpPkg::csrCmdT c);
        @(negedge clk);
        cmd      = c;
        cmdValid = 1'b1;
    endtask

    task automatic stopCmd();
        @(negedge clk);
        cmdValid = 1'b0;
        cmd      = '0;
    endtask

    task automatic getRsp(output csrOpPkg::csrRspT r);
        while (rspQ.size() == 0) begin
            @(negedge clk);
        end
        r = rspQ.pop_front();
    endtask

    task automatic checkRsp(input string tag, input csrOpPkg::csrRspT got,
                            input csrOpPkg::csrRspT exp);
        if (got.readData !== exp.readData) begin
            $display("error rsp.readData (%s): got 0x%08h, expected 0x%08h",
                     tag, got.readData, exp.readData);
            valueErrors = valueErrors + 1;
        end
        if (got.redirectValid !== exp.redirectValid) begin
            $display("error rsp.redirectValid (%s): got 0x%0h, expected 0x%0h",
                     tag, got.redirectValid, exp.redirectValid);
            valueErrors = valueErrors + 1;
        end
        if (got.redirectTarget !== exp.redirectTarget) begin
            $display("error rsp.redirectTarget (%s): got 0x%08h, expected 0x%08h",
                     tag, got.redirectTarget, exp.redirectTarget);
            valueErrors = valueErrors + 1;
        end
        if (got.isIllegal !== exp.isIllegal) begin
            $display("error rsp.isIllegal (%s): got 0x%0h, expected 0x%0h",
                     tag, got.isIllegal, exp.isIllegal);
            valueErrors = valueErrors + 1;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            valueErrors = valueErrors + 1;
        end
    endtask

    // One command in, one response checked
    task automatic runCmd(input csrOpPkg::csrCmdT c, input csrOpPkg::csrRspT exp,
                          input string tag);
        csrOpPkg::csrRspT r;
        sendCmd(c);
        stopCmd();
        getRsp(r);
        checkRsp(tag, r, exp);
    endtask

    task automatic csrOp(input logic [11:0] num, input logic [2:0] f3, input logic [4:0] src,
                         input logic [31:0] rs1, input logic [31:0] expOld, input string tag);
        runCmd(accessCmd(num, f3, src, rs1), readRsp(expOld), tag);
    endtask

    task automatic accessSequence(input logic [11:0] num, input string name);
        logic [31:0] model;
        logic [31:0] mask;
        logic [31:0] v;
        logic [4:0]  imm;
        // mtvec mode bits always read as direct
        mask  = (num == `CSR_NUM_MTVEC) ? 32'hFFFF_FFFC : 32'hFFFF_FFFF;
        model = (num == `CSR_NUM_MTVEC) ? mtvecModel : mscratchModel;
        imm = 5'(nextRand());
        csrOp(num, 3'b101, imm, 32'h0, model, {name, " csrrwi"});
        model = 32'(imm) & mask;
        imm = 5'(nextRand());
        csrOp(num, 3'b110, imm, 32'h0, model, {name, " csrrsi"});
        model = (model | 32'(imm)) & mask;
        imm = 5'(nextRand());
        csrOp(num, 3'b111, imm, 32'h0, model, {name, " csrrci"});
        model = model & ~32'(imm);
        v = nextRand();
        csrOp(num, 3'b001, 5'd1, v, model, {name, " csrrw"});
        model = v & mask;
        v = nextRand();
        csrOp(num, 3'b010, 5'd2, v, model, {name, " csrrs"});
        model = (model | v) & mask;
        v = nextRand();
        csrOp(num, 3'b011, 5'd3, v, model, {name, " csrrc"});
        model = model & ~v;
        // x0 source never writes, whatever rs1Value carries
        csrOp(num, 3'b010, 5'd0, nextRand(), model, {name, " csrrs x0"});
        csrOp(num, 3'b011, 5'd0, nextRand(), model, {name, " csrrc x0"});
        csrOp(num, 3'b111, 5'd0, 32'h0, model, {name, " csrrci 0"});
        if (num == `CSR_NUM_MTVEC) begin
            mtvecModel = model;
        end else begin
            mscratchModel = model;
        end
    endtask

    task automatic trapEntry();
        csrOpPkg::csrCmdT c;
        c = '0;
        c.kind      = csrOpPkg::kindTrap;
        c.pc        = nextRand() & 32'hFFFF_FFFC;
        c.faultAddr = nextRand();
        c.trapCode  = csrRegPkg::trapLoadMisaligned;
        csrOp(`CSR_NUM_MSTATUS, 3'b110, 5'd8, 32'h0, mstatusValue(), "mstatus set MIE");
        mieModel = 1'b1;
        runCmd(c, redirectRsp(mtvecModel, 1'b0), "trap redirect");
        mpieModel = mieModel;
        mieModel  = 1'b0;
        mepcModel = c.pc;
        csrOp(`CSR_NUM_MEPC, 3'b010, 5'd0, 32'h0, c.pc, "mepc after trap");
        csrOp(`CSR_NUM_MTVAL, 3'b010, 5'd0, 32'h0, c.faultAddr, "mtval after trap");
        // Load address misaligned is cause 4, interrupt flag clear
        csrOp(`CSR_NUM_MCAUSE, 3'b010, 5'd0, 32'h0, 32'd4, "mcause after trap");
        csrOp(`CSR_NUM_MSTATUS, 3'b010, 5'd0, 32'h0, mstatusValue(), "mstatus after trap");
    endtask

    task automatic mretReturn();
        csrOpPkg::csrCmdT c;
        c      = '0;
        c.kind = csrOpPkg::kindMret;
        c.pc   = nextRand();
        runCmd(c, redirectRsp(mepcModel, 1'b0), "mret redirect");
        mieModel = mpieModel;
        csrOp(`CSR_NUM_MSTATUS, 3'b010, 5'd0, 32'h0, mstatusValue(), "mstatus after mret");
    endtask

    task automatic illegalAccess();
        csrOpPkg::csrCmdT c;
        c    = accessCmd(12'h7C0, 3'b001, 5'd1, nextRand());
        c.pc = nextRand() & 32'hFFFF_FFFC;
        runCmd(c, redirectRsp(mtvecModel, 1'b1), "illegal access");
        mpieModel = mieModel;
        mieModel  = 1'b0;
        mepcModel = c.pc;
        csrOp(`CSR_NUM_MTVAL, 3'b010, 5'd0, 32'h0, c.insn, "mtval after illegal");
        csrOp(`CSR_NUM_MEPC, 3'b010, 5'd0, 32'h0, c.pc, "mepc after illegal");
        csrOp(`CSR_NUM_MCAUSE, 3'b010, 5'd0, 32'h0, 32'd2, "mcause after illegal");
    endtask

    task automatic timerInterrupt();
        csrOpPkg::csrCmdT c;
        logic [31:0]      timerBit;
        timerBit = 32'h1 << `CSR_MTIP_BIT;
        csrOp(`CSR_NUM_MSTATUS, 3'b110, 5'd8, 32'h0, mstatusValue(), "mstatus set MIE");
        mieModel = 1'b1;
        csrOp(`CSR_NUM_MIE, 3'b010, 5'd1, timerBit, 32'h0, "mie set MTIE");
        // Enabled but nothing pending yet
        checkBit("intPending", intPending, 1'b0);
        @(negedge clk);
        timerIrq = 1'b1;
        // mip samples, then intPending follows one cycle later
        repeat (3) @(negedge clk);
        checkBit("intPending", intPending, 1'b1);
        csrOp(`CSR_NUM_MIP, 3'b010, 5'd0, 32'h0, timerBit, "mip with timer");
        csrOp(`CSR_NUM_MIE, 3'b001, 5'd1, 32'h0, timerBit, "mie clear");
        repeat (3) @(negedge clk);
        checkBit("intPending", intPending, 1'b0);
        c = '0;
        c.kind          = csrOpPkg::kindInterrupt;
        c.pc            = nextRand() & 32'hFFFF_FFFC;
        c.interruptCode = csrRegPkg::intMachineTimer;
        runCmd(c, redirectRsp(mtvecModel, 1'b0), "timer interrupt");
        mpieModel = mieModel;
        mieModel  = 1'b0;
        mepcModel = c.pc;
        csrOp(`CSR_NUM_MCAUSE, 3'b010, 5'd0, 32'h0, 32'h8000_0007, "mcause after irq");
        csrOp(`CSR_NUM_MEPC, 3'b010, 5'd0, 32'h0, c.pc, "mepc after irq");
        @(negedge clk);
        timerIrq = 1'b0;
    endtask

    task automatic counterUpdates();
        csrOpPkg::csrCmdT c;
        csrOpPkg::csrRspT r;
        logic [31:0]      v;
        logic [31:0]      sum;
        v = nextRand();
        // Back to back, so the read sees mcycle right after the write
        sendCmd(accessCmd(`CSR_NUM_MCYCLE, 3'b001, 5'd1, v));
        sendCmd(accessCmd(`CSR_NUM_MCYCLE, 3'b010, 5'd0, 32'h0));
        stopCmd();
        getRsp(r);
        getRsp(r);
        checkRsp("mcycle readback", r, readRsp(v));
        // No retire counts were sent so far
        csrOp(`CSR_NUM_MINSTRET, 3'b001, 5'd1, 32'h0, 32'h0, "minstret write 0");
        sum = '0;
        for (int i = 0; i < 6; i++) begin
            c             = '0;
            c.retireCount = 2'(nextRand());
            sum           = sum + 32'(c.retireCount);
            sendCmd(c);
            // Idle cycle whose retire count must not reach minstret
            @(negedge clk);
            cmdValid        = 1'b0;
            cmd.retireCount = 2'b11;
        end
        stopCmd();
        for (int i = 0; i < 6; i++) begin
            getRsp(r);
            checkRsp("retire only", r, readRsp(32'h0));
        end
        csrOp(`CSR_NUM_MINSTRET, 3'b010, 5'd0, 32'h0, sum, "minstret sum");
    endtask

    initial begin
        arstN         = 1'b0;
        cmdValid      = 1'b0;
        cmd           = '0;
        timerIrq      = 1'b0;
        externalIrq   = 1'b0;
        rngState      = 32'h72d2;
        cycleCount    = 0;
        valueErrors   = 0;
        otherErrors   = 0;
        mscratchModel = '0;
        mtvecModel    = '0;
        mepcModel     = '0;
        mieModel      = 1'b0;
        mpieModel     = 1'b0;
        repeat (3) @(negedge clk);
        arstN = 1'b1;

        accessSequence(`CSR_NUM_MSCRATCH, "mscratch");
        accessSequence(`CSR_NUM_MTVEC, "mtvec");
        trapEntry();
        mretReturn();
        illegalAccess();
        timerInterrupt();
        counterUpdates();

        repeat (4) @(negedge clk);
        if (rspQ.size() != 0) begin
            $display("%0d responses arrived without a matching command", rspQ.size());
            otherErrors = otherErrors + 1;
        end
        otherErrors = otherErrors + u_csrSubsystem.uChk.failCount;
        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/csrDecode.sv ====
// ******************
// CSR decode stage
// Splits the CSR instruction and turns unknown registers into traps
// ******************
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csrDecode (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    cmdValid,
    input  csrOpPkg::csrCmdT        cmd,
    output logic                    decValid,
    output csrOpPkg::csrDecodedT    dec
);

    logic [11:0]            csrNum;
    logic [2:0]             funct3;
    logic [4:0]             src;
    logic                   isKnown;
    csrOpPkg::csrDecodedT   decNext;

    assign csrNum = cmd.insn[31:20];
    assign src    = cmd.insn[19:15];
    assign funct3 = cmd.insn[14:12];

    assign isKnown = (funct3[1:0] != 2'b00) && (csrNum inside {
        `CSR_NUM_MSTATUS, `CSR_NUM_MIE, `CSR_NUM_MIP, `CSR_NUM_MCAUSE,
        `CSR_NUM_MTVEC, `CSR_NUM_MTVAL, `CSR_NUM_MEPC, `CSR_NUM_MSCRATCH,
        `CSR_NUM_MCYCLE, `CSR_NUM_MINSTRET});

    always_comb begin
        decNext             = '0;
        decNext.kind        = cmd.kind;
        decNext.funct       = csrOpPkg::csrFunctT'(funct3[1:0]);
        decNext.csrNumber   = csrNum;
        decNext.pc          = cmd.pc;
        // Immediate forms carry a 5-bit zero-extended value in rs1
        decNext.operand     = funct3[2] ? {{(`CSR_XLEN-5){1'b0}}, src} : cmd.rs1Value;

        case (cmd.kind)
            csrOpPkg::kindCsrAccess: begin
                if (isKnown) begin
                    // set/clear with x0 or a zero immediate is a pure read
                    decNext.writeEnable = (funct3[1:0] == 2'b01) || (src != 5'd0);
                end else begin
                    decNext.kind                    = csrOpPkg::kindTrap;
                    decNext.tval                    = cmd.insn;
                    decNext.cause.trap.isInterrupt  = 1'b0;
                    decNext.cause.trap.code         = csrRegPkg::trapIllegalInsn;
                end
            end
            csrOpPkg::kindTrap: begin
                decNext.tval                    = cmd.faultAddr;
                decNext.cause.trap.isInterrupt  = 1'b0;
                decNext.cause.trap.code         = cmd.trapCode;
            end
            csrOpPkg::kindInterrupt: begin
                decNext.tval                    = cmd.pc;
                decNext.cause.intr.isInterrupt  = 1'b1;
                decNext.cause.intr.code         = cmd.interruptCode;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decValid <= 1'b0;
        end else begin
            decValid <= cmdValid;
        end
    end

    always_ff @(posedge clk) begin
        dec <= decNext;
    end

endmodule

`default_nettype wire

// ==== rtl/csrFile.sv ====
// ******************
// CSR register file stage
// Holds the machine-mode registers, applies CSR ops, trap, mret,
// interrupt entry and the counters
// ******************
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csrFile (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        decValid,
    input  csrOpPkg::csrDecodedT        dec,
    input  logic [`CSR_RETIRE_W-1:0]    retireCount,
    input  logic                        timerIrq,
    input  logic                        externalIrq,
    output logic                        fileValid,
    output csrOpPkg::cmdKindT           fileKind,
    output csrOpPkg::csrRspT            fileRsp,
    output csrRegPkg::csrBodyT          body
);

    csrRegPkg::csrBodyT     csrReg;
    csrRegPkg::csrBodyT     csrNext;
    logic [`CSR_XLEN-1:0]   rv;
    logic [`CSR_XLEN-1:0]   wv;
    csrOpPkg::csrRspT       rspNext;

    // Read side, always from the state before this command
    always_comb begin
        case (dec.csrNumber)
            `CSR_NUM_MSTATUS:   rv = csrReg.mstatus;
            `CSR_NUM_MIE:       rv = csrReg.mie;
            `CSR_NUM_MIP:       rv = csrReg.mip;
            `CSR_NUM_MCAUSE:    rv = csrReg.mcause;
            `CSR_NUM_MTVEC:     rv = {csrReg.mtvec.base, 2'b00};
            `CSR_NUM_MTVAL:     rv = csrReg.mtval;
            `CSR_NUM_MEPC:      rv = csrReg.mepc;
            `CSR_NUM_MSCRATCH:  rv = csrReg.mscratch;
            `CSR_NUM_MCYCLE:    rv = csrReg.mcycle;
            `CSR_NUM_MINSTRET:  rv = csrReg.minstret;
            default:            rv = '0;
        endcase

        case (dec.funct)
            csrOpPkg::functSet:     wv = rv | dec.operand;
            csrOpPkg::functClear:   wv = rv & ~dec.operand;
            default:                wv = dec.operand;
        endcase
    end

    always_comb begin
        csrNext          = csrReg;
        csrNext.mcycle   = csrReg.mcycle + 1'b1;
        csrNext.minstret = csrReg.minstret + `CSR_XLEN'(retireCount);

        if (decValid) begin
            case (dec.kind)
                csrOpPkg::kindTrap, csrOpPkg::kindInterrupt: begin
                    csrNext.mstatus.mpie = csrReg.mstatus.mie;
                    csrNext.mstatus.mie  = 1'b0;
                    csrNext.mepc         = dec.pc;
                    csrNext.mtval        = dec.tval;
                    if (dec.kind == csrOpPkg::kindInterrupt) begin
                        csrNext.mcause.intr.isInterrupt = 1'b1;
                        csrNext.mcause.intr.code        = dec.cause.intr.code;
                    end else begin
                        csrNext.mcause.trap.isInterrupt = 1'b0;
                        csrNext.mcause.trap.code        = dec.cause.trap.code;
                    end
                end
                csrOpPkg::kindMret: begin
                    csrNext.mstatus.mie = csrReg.mstatus.mpie;
                end
                csrOpPkg::kindCsrAccess: begin
                    if (dec.writeEnable) begin
                        case (dec.csrNumber)
                            `CSR_NUM_MSTATUS: begin
                                csrNext.mstatus.mie  = wv[`CSR_MIE_BIT];
                                csrNext.mstatus.mpie = wv[`CSR_MPIE_BIT];
                            end
                            `CSR_NUM_MIE:       csrNext.mie = wv;
                            `CSR_NUM_MCAUSE:    csrNext.mcause = csrRegPkg::mcauseU'(wv);
                            `CSR_NUM_MTVEC:     csrNext.mtvec = csrRegPkg::mtvecT'(wv);
                            `CSR_NUM_MTVAL:     csrNext.mtval = wv;
                            `CSR_NUM_MEPC:      csrNext.mepc = wv;
                            `CSR_NUM_MSCRATCH:  csrNext.mscratch = wv;
                            // A written counter does not count this cycle
                            `CSR_NUM_MCYCLE:    csrNext.mcycle = wv;
                            `CSR_NUM_MINSTRET:  csrNext.minstret = wv;
                            // mip is read-only
                            default: ;
                        endcase
                    end
                end
                default: ;
            endcase
        end

        // Interrupt lines are level, sampled every edge
        csrNext.mip[`CSR_MTIP_BIT] = timerIrq;
        csrNext.mip[`CSR_MEIP_BIT] = externalIrq;
    end

    always_comb begin
        rspNext                = '0;
        rspNext.readData       = (dec.kind == csrOpPkg::kindCsrAccess) ? rv : '0;
        rspNext.isIllegal      = (dec.kind == csrOpPkg::kindTrap) &&
                                 (dec.cause.trap.code == csrRegPkg::trapIllegalInsn);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            csrReg    <= '0;
            fileValid <= 1'b0;
            fileKind  <= csrOpPkg::kindNone;
        end else begin
            csrReg    <= csrNext;
            fileValid <= decValid;
            fileKind  <= dec.kind;
        end
    end

    always_ff @(posedge clk) begin
        fileRsp <= rspNext;
    end

    assign body = csrReg;

endmodule

`default_nettype wire

// ==== rtl/csrOpPkg.sv ====
// ******************
// CSR command types
// Command kinds, CSR operations and the structs between stages
// ******************
`default_nettype none

`include "csr_consts.svh"

package csrOpPkg;

    typedef enum logic [2:0] {
        kindNone      = 3'd0,
        kindCsrAccess = 3'd1,
        kindTrap      = 3'd2,
        kindMret      = 3'd3,
        kindInterrupt = 3'd4
    } cmdKindT;

    // Encoded as funct3[1:0] of the CSR instructions
    typedef enum logic [1:0] {
        functWrite = 2'b01,
        functSet   = 2'b10,
        functClear = 2'b11
    } csrFunctT;

    typedef struct packed {
        cmdKindT                    kind;
        logic [31:0]                insn;
        logic [`CSR_XLEN-1:0]       rs1Value;
        logic [`CSR_XLEN-1:0]       pc;
        logic [`CSR_XLEN-1:0]       faultAddr;
        csrRegPkg::trapCodeT        trapCode;
        csrRegPkg::interruptCodeT   interruptCode;
        logic [`CSR_RETIRE_W-1:0]   retireCount;
    } csrCmdT;

    typedef struct packed {
        cmdKindT                kind;
        csrFunctT               funct;
        logic [11:0]            csrNumber;
        logic [`CSR_XLEN-1:0]   operand;
        logic                   writeEnable;
        logic [`CSR_XLEN-1:0]   pc;
        logic [`CSR_XLEN-1:0]   tval;
        csrRegPkg::mcauseU      cause;
    } csrDecodedT;

    typedef struct packed {
        logic [`CSR_XLEN-1:0]   readData;
        logic                   redirectValid;
        logic [`CSR_XLEN-1:0]   redirectTarget;
        logic                   isIllegal;
    } csrRspT;

endpackage

`default_nettype wire

// ==== rtl/csrRedirect.sv ====
// ******************
// CSR redirect stage
// Picks the redirect target, registers the response and
// flags pending interrupts
// ******************
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csrRedirect (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    fileValid,
    input  csrOpPkg::csrRspT        fileRsp,
    input  csrOpPkg::cmdKindT       fileKind,
    input  csrRegPkg::csrBodyT      body,
    output logic                    rspValid,
    output csrOpPkg::csrRspT        rsp,
    output logic                    intPending
);

    csrOpPkg::csrRspT       rspNext;
    logic                   pendNow;

    always_comb begin
        rspNext = fileRsp;
        rspNext.redirectValid  = 1'b0;
        rspNext.redirectTarget = '0;

        case (fileKind)
            // body already holds the state after this command
            csrOpPkg::kindMret: begin
                rspNext.redirectValid  = fileValid;
                rspNext.redirectTarget = body.mepc;
            end
            csrOpPkg::kindTrap, csrOpPkg::kindInterrupt: begin
                rspNext.redirectValid  = fileValid;
                rspNext.redirectTarget = {body.mtvec.base, 2'b00};
            end
            default: ;
        endcase
    end

    // Global enable plus any enabled and pending source
    assign pendNow = body.mstatus.mie && |(body.mip & body.mie);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rspValid   <= 1'b0;
            rsp        <= '0;
            intPending <= 1'b0;
        end else begin
            rspValid   <= fileValid;
            rsp        <= rspNext;
            intPending <= pendNow;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/csrRegPkg.sv ====
// ******************
// CSR register layouts
// Field views of the machine-mode registers and the whole register body
// ******************
`default_nettype none

`include "csr_consts.svh"

package csrRegPkg;

    // Only MIE and MPIE are implemented
    typedef struct packed {
        logic [`CSR_XLEN-1:`CSR_MPIE_BIT+1]     rsvHi;
        logic                                   mpie;
        logic [`CSR_MPIE_BIT-1:`CSR_MIE_BIT+1]  rsvMid;
        logic                                   mie;
        logic [`CSR_MIE_BIT-1:0]                rsvLo;
    } mstatusT;

    // Mode bits are stored but the unit always behaves as direct mode
    typedef struct packed {
        logic [`CSR_XLEN-3:0]   base;
        logic [1:0]             mode;
    } mtvecT;

    typedef enum logic [`CSR_XLEN-2:0] {
        intMachineTimer    = 31'd7,
        intMachineExternal = 31'd11
    } interruptCodeT;

    typedef enum logic [`CSR_XLEN-2:0] {
        trapIllegalInsn     = 31'd2,
        trapBreakpoint      = 31'd3,
        trapLoadMisaligned  = 31'd4,
        trapStoreMisaligned = 31'd6,
        trapEcallM          = 31'd11
    } trapCodeT;

    typedef struct packed {
        logic           isInterrupt;
        interruptCodeT  code;
    } mcauseIntT;

    typedef struct packed {
        logic       isInterrupt;
        trapCodeT   code;
    } mcauseTrapT;

    // Same word, read as interrupt or as synchronous trap cause
    typedef union packed {
        mcauseIntT  intr;
        mcauseTrapT trap;
    } mcauseU;

    typedef struct packed {
        mstatusT                mstatus;
        logic [`CSR_XLEN-1:0]   mie;
        logic [`CSR_XLEN-1:0]   mip;
        mcauseU                 mcause;
        mtvecT                  mtvec;
        logic [`CSR_XLEN-1:0]   mtval;
        logic [`CSR_XLEN-1:0]   mepc;
        logic [`CSR_XLEN-1:0]   mscratch;
        logic [`CSR_XLEN-1:0]   mcycle;
        logic [`CSR_XLEN-1:0]   minstret;
    } csrBodyT;

endpackage

`default_nettype wire

// ==== rtl/csrSubsystem.sv ====
// ******************
// CSR subsystem top
// Decode, register file and redirect stages in a chain
// ******************
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csrSubsystem (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    cmdValid,
    input  csrOpPkg::csrCmdT        cmd,
    input  logic                    timerIrq,
    input  logic                    externalIrq,
    output logic                    rspValid,
    output csrOpPkg::csrRspT        rsp,
    output logic                    intPending
);

    logic                       decValid;
    csrOpPkg::csrDecodedT       dec;
    logic                       fileValid;
    csrOpPkg::cmdKindT          fileKind;
    csrOpPkg::csrRspT           fileRsp;
    csrRegPkg::csrBodyT         body;
    logic [`CSR_RETIRE_W-1:0]   retireCount;

    // Retired count only counts with a valid commit
    assign retireCount = cmdValid ? cmd.retireCount : '0;

    csrDecode uDecode (
        .clk      (clk),
        .arstN    (arstN),
        .cmdValid (cmdValid),
        .cmd      (cmd),
        .decValid (decValid),
        .dec      (dec)
    );

    csrFile uFile (
        .clk         (clk),
        .arstN       (arstN),
        .decValid    (decValid),
        .dec         (dec),
        .retireCount (retireCount),
        .timerIrq    (timerIrq),
        .externalIrq (externalIrq),
        .fileValid   (fileValid),
        .fileKind    (fileKind),
        .fileRsp     (fileRsp),
        .body        (body)
    );

    csrRedirect uRedirect (
        .clk        (clk),
        .arstN      (arstN),
        .fileValid  (fileValid),
        .fileRsp    (fileRsp),
        .fileKind   (fileKind),
        .body       (body),
        .rspValid   (rspValid),
        .rsp        (rsp),
        .intPending (intPending)
    );

endmodule

`default_nettype wire

// ==== rtl/csr_consts.svh ====
// ******************
// CSR unit constants
// Register addresses, field positions and widths
// ******************
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

`define CSR_XLEN            32
`define CSR_RETIRE_W        2

// Machine-mode register addresses
`define CSR_NUM_MSTATUS     12'h300
`define CSR_NUM_MIE         12'h304
`define CSR_NUM_MTVEC       12'h305
`define CSR_NUM_MSCRATCH    12'h340
`define CSR_NUM_MEPC        12'h341
`define CSR_NUM_MCAUSE      12'h342
`define CSR_NUM_MTVAL       12'h343
`define CSR_NUM_MIP         12'h344
`define CSR_NUM_MCYCLE      12'hB00
`define CSR_NUM_MINSTRET    12'hB02

// Bit positions in mstatus, mip and mie
`define CSR_MIE_BIT         3
`define CSR_MPIE_BIT        7
`define CSR_MTIP_BIT        7
`define CSR_MEIP_BIT        11

`endif

// ==== run.sh ====
#!/bin/sh
# Build and run the CSR subsystem simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module csrSubsystem_tb -f verilog.f -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

// ==== verilog.f ====
+incdir+rtl
rtl/csrRegPkg.sv
rtl/csrOpPkg.sv
rtl/csrDecode.sv
rtl/csrFile.sv
rtl/csrRedirect.sv
rtl/csrSubsystem.sv
dv/csrSubsystem_chk.sv
dv/csrSubsystem_tb.sv
